//--- vlog.f
source/controlPkg.sv
source/opcodeDecoder.sv
source/stepSequencer.sv
source/controlEncoder.sv
source/controlUnit.sv
dv/controlUnit_sva.sv
dv/controlChecker.sv
dv/controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "make test    build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "make clean   remove $(OBJ_DIR) and $(LOG)"
	@echo "make help    show this list"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb
    import controlPkg::*;
();

    localparam int resetCycles  = 4;
    localparam int holdCycles   = 6;
    localparam int randomCycles = 3000;
    localparam int endCycles    = 40;
    localparam int watchdogNs   = (resetCycles + holdCycles + randomCycles + endCycles) * 10 + 500;

    logic    clk;
    logic    rst;
    logic    start;
    logic    zout;
    instrT   ins;
    aluOpT   aluOp;
    incVecT  incReg;
    wrEnVecT wrEnReg;
    busSelT  busSel;
    logic    dMemWrEn;
    logic    zWrEn;
    logic    done;
    logic    ready;

    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          endErrors;

    controlUnit uut (.*);

    controlChecker scoreboard (.*);

    bind controlUnit controlUnitSva sva (
        .clk      (clk),
        .rst      (rst),
        .ready    (ready),
        .done     (done),
        .dMemWrEn (dMemWrEn),
        .wrEnReg  (wrEnReg)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    // mostly valid opcodes with ENDOP kept back for the last phase
    task automatic pickOpcode(output instrT op);
        logic [31:0] r;
        logic [31:0] low;
        takeBits(5, r);
        if (r == 32'd1) begin
            op = opNop;
        end else if (r < 32'd14) begin
            op = r[7:0];
        end else if (r < 32'd23) begin
            op = {r[3:0] + 4'd3, 4'hf};  // selector 1 to 9
        end else if (r < 32'd30) begin
            op = r[7:0] - 8'd16;  // branches and ALU ops again
        end else begin
            takeBits(4, low);
            op = {4'he, low[3:0]};  // never a valid opcode
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired before the run reached its end");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] bits;
        lfsrState = 32'h942b;
        endErrors = 0;
        rst   = 1'b0;
        start = 1'b1;
        zout  = 1'b0;
        ins   = opNop;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b1;
        repeat (holdCycles) @(posedge clk);  // start held high so the unit stays in idle
        for (int c = 0; c < randomCycles; c++) begin
            @(posedge clk);
            #1;
            takeBits(1, bits);
            start = bits[0];
            takeBits(1, bits);
            zout = bits[0];
            pickOpcode(ins);
        end
        for (int c = 0; c < endCycles; c++) begin
            @(posedge clk);
            #1;
            takeBits(1, bits);
            zout  = bits[0];
            start = 1'b0;
            ins   = opEndop;
        end
        @(negedge clk);
        #1;
        if (!done) begin
            endErrors++;
            $display("the run ended without reaching ENDOP, done is still low");
        end
        $display("checks %0d, mismatches %0d, other errors %0d",
            checkCount, errorCount, endErrors);
        if (errorCount == 0 && endErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- dv/controlChecker.sv
`timescale 1ns/1ps

module controlChecker
    import controlPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    zout,
    input  instrT   ins,
    input  aluOpT   aluOp,
    input  incVecT  incReg,
    input  wrEnVecT wrEnReg,
    input  busSelT  busSel,
    input  logic    dMemWrEn,
    input  logic    zWrEn,
    input  logic    done,
    input  logic    ready,
    output int      errorCount,
    output int      checkCount
);

    typedef struct packed {
        aluOpT   alu;
        incVecT  inc;
        wrEnVecT wr;
        busSelT  bus;
        logic    dMem;
        logic    zWr;
        logic    done;
        logic    ready;
    } wordT;

    stepT model;
    int   errors = 0;
    int   checks = 0;

    // branch opcodes are resolved in firstStep so their entries stay unused
    stepT plainFirst [0:13] = '{stepNop, stepEndop, stepClac, stepLdiacWait1, stepLdac1,
        stepStr1, stepStirWait1, stepJumpWait, stepIdle, stepIdle, stepMul, stepAdd,
        stepSub, stepIncac};
    stepT moveFirst [1:9] = '{stepMvRlAc, stepMvRpAc, stepMvRqAc, stepMvRcAc, stepMvRAc,
        stepMvR1Ac, stepMvAcRp, stepMvAcRq, stepMvAcRl};

    assign errorCount = errors;
    assign checkCount = checks;

    function automatic stepT firstStep(instrT i, logic z);
        if (i == opJmpnz)
            return z ? stepJmpnzN : stepJmpnzYWait;
        if (i == opJmpz)
            return z ? stepJmpzYWait : stepJmpzN;
        if (i <= opIncac)
            return plainFirst[i[3:0]];
        if (i[3:0] == 4'hf && i[7:4] >= 4'd1 && i[7:4] <= 4'd9)
            return moveFirst[i[7:4]];
        return stepIdle;  // unknown byte
    endfunction

    function automatic stepT nextOf(stepT s, instrT i, logic z, logic st);
        case (s)
            stepIdle:                        return st ? stepIdle : stepFetch1;
            stepEndop:                       return stepEndop;
            stepNop, stepStr2, stepFetchWait: return stepFetch1;
            stepFetch1:                      return stepFetch2;
            stepFetch2:                      return firstStep(i, z);
            stepLdiac3, stepLdac2, stepStir3, stepJump2, stepJmpnzY2, stepJmpnzN,
            stepJmpzY2, stepJmpzN, stepClac, stepMul, stepAdd, stepSub, stepIncac,
            stepMvRlAc, stepMvRpAc, stepMvRqAc, stepMvRcAc, stepMvRAc, stepMvR1Ac,
            stepMvAcRp, stepMvAcRq, stepMvAcRl: return stepFetchWait;
            default:                         return s.next();  // wait chains run in enum order
        endcase
    endfunction

    function automatic wordT expectedWord(stepT s);
        wordT w;
        w       = '0;
        w.alu   = aluNone;
        w.bus   = busNone;
        w.done  = (s == stepEndop);
        w.ready = (s == stepIdle);
        case (s)
            stepClac:  w.alu = aluClr;
            stepMul:   w.alu = aluMul;
            stepAdd:   w.alu = aluAdd;
            stepSub:   w.alu = aluSub;
            stepIncac: w.alu = aluInc;
            stepLdiacWait2, stepLdiac3, stepLdacWait, stepLdac2,
            stepMvAcRp, stepMvAcRq, stepMvAcRl: w.alu = aluPass;
            default: ;
        endcase
        w.wr[wrAc] = (w.alu != aluNone);  // every ALU result lands in AC
        w.zWr      = (w.alu != aluNone);
        case (s)
            stepEndop, stepFetch2, stepLdiacWait2, stepLdiac3, stepLdacWait, stepLdac2,
            stepJumpWait, stepJump1, stepJmpnzYWait, stepJmpnzY1, stepJmpzYWait,
            stepJmpzY1: w.bus = busDMem;
            stepLdiac2, stepStir2, stepJump2, stepJmpnzY2, stepJmpzY2: w.bus = busIR;
            stepLdac1, stepStr1, stepMvRlAc, stepMvRpAc, stepMvRqAc, stepMvRcAc, stepMvRAc,
            stepMvR1Ac: w.bus = busAC;
            stepMul:    w.bus = busR1;
            stepAdd:    w.bus = busR;
            stepSub:    w.bus = busRC;
            stepMvAcRp: w.bus = busRP;
            stepMvAcRq: w.bus = busRQ;
            stepMvAcRl: w.bus = busRL;
            default: ;
        endcase
        case (s)
            stepFetchWait, stepFetch1, stepLdiacWait1, stepLdiac1, stepStirWait1, stepStir1,
            stepJumpWait, stepJump1, stepJmpnzYWait, stepJmpnzY1, stepJmpzYWait,
            stepJmpzY1: w.wr[wrIr] = 1'b1;
            stepLdiac2, stepStir2, stepLdac1, stepStr1: w.wr[wrAr] = 1'b1;
            stepJump2, stepJmpnzY2, stepJmpzY2: w.wr[wrPc] = 1'b1;
            stepMvRlAc: w.wr[wrRl] = 1'b1;
            stepMvRpAc: w.wr[wrRp] = 1'b1;
            stepMvRqAc: w.wr[wrRq] = 1'b1;
            stepMvRcAc: w.wr[wrRc] = 1'b1;
            stepMvRAc:  w.wr[wrR]  = 1'b1;
            stepMvR1Ac: w.wr[wrR1] = 1'b1;
            default: ;
        endcase
        w.inc[incPc] = (s inside {stepFetch2, stepLdiac2, stepStir2, stepJmpnzN, stepJmpzN});
        {w.inc[incRc], w.inc[incRp], w.inc[incRq]} = {3{s == stepMul}};  // MUL walks the matrices
        w.dMem = (s inside {stepStrWait, stepStr2, stepStirWait2, stepStir3});
        return w;
    endfunction

    task automatic checkField(input string name, input logic [9:0] want, input logic [9:0] seen);
        checks++;
        if (seen !== want) begin
            errors++;
            $display("mismatch %s: expected %0h, got %0h (step %s, %0t)",
                name, want, seen, model.name(), $time);
        end
    endtask

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            model <= stepIdle;
        end else begin
            model <= nextOf(model, ins, zout, start);
        end
    end

    // outputs settle from the registered step well before the falling edge
    always @(negedge clk) begin
        wordT want;
        wordT seen;
        want = expectedWord(model);
        seen = {aluOp, incReg, wrEnReg, busSel, dMemWrEn, zWrEn, done, ready};
        checkField("aluOp", 10'(want.alu), 10'(seen.alu));
        checkField("incReg", 10'(want.inc), 10'(seen.inc));
        checkField("wrEnReg", want.wr, seen.wr);
        checkField("busSel", 10'(want.bus), 10'(seen.bus));
        checkField("dMemWrEn", 10'(want.dMem), 10'(seen.dMem));
        checkField("zWrEn", 10'(want.zWr), 10'(seen.zWr));
        checkField("done", 10'(want.done), 10'(seen.done));
        checkField("ready", 10'(want.ready), 10'(seen.ready));
    end

endmodule

//--- dv/controlUnit_sva.sv
`timescale 1ns/1ps

module controlUnitSva
    import controlPkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    ready,
    input logic    done,
    input logic    dMemWrEn,
    input wrEnVecT wrEnReg
);

    wrEnVecT otherWrites;

    assign otherWrites = wrEnReg & ~(wrEnVecT'(1) << wrAr);  // AR may load with a store

    readyNotDone: assert property (@(posedge clk) disable iff (!rst) !(ready && done))
        else $error("ready and done are high in the same cycle");

    storeAlone: assert property (@(posedge clk) disable iff (!rst)
        dMemWrEn |-> otherWrites == '0)
        else $error("data memory write overlaps a register write");

    // halted until reset
    doneHolds: assert property (@(posedge clk) disable iff (!rst) done |=> done)
        else $error("done dropped after ENDOP");

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
    import controlPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,  // active low
    input  logic    zout,
    input  instrT   ins,
    output aluOpT   aluOp,
    output incVecT  incReg,
    output wrEnVecT wrEnReg,
    output busSelT  busSel,
    output logic    dMemWrEn,
    output logic    zWrEn,
    output logic    done,
    output logic    ready
);

    instrKindT kind;
    stepT      step;

    opcodeDecoder decoder (
        .ins  (ins),
        .kind (kind)
    );

    stepSequencer sequencer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .zout  (zout),
        .kind  (kind),
        .step  (step)
    );

    // outputs are a pure function of the registered step
    controlEncoder encoder (
        .step     (step),
        .aluOp    (aluOp),
        .incReg   (incReg),
        .wrEnReg  (wrEnReg),
        .busSel   (busSel),
        .dMemWrEn (dMemWrEn),
        .zWrEn    (zWrEn),
        .done     (done),
        .ready    (ready)
    );

endmodule

//--- source/controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder
    import controlPkg::*;
(
    input  stepT    step,
    output aluOpT   aluOp,
    output incVecT  incReg,
    output wrEnVecT wrEnReg,
    output busSelT  busSel,
    output logic    dMemWrEn,
    output logic    zWrEn,
    output logic    done,
    output logic    ready
);

    always_comb begin
        // idle control word that each step overrides below
        aluOp    = aluNone;
        incReg   = '0;
        wrEnReg  = '0;
        busSel   = busNone;
        dMemWrEn = 1'b0;
        zWrEn    = 1'b0;

        case (step)
            stepEndop: begin
                busSel = busDMem;
            end

            stepClac: begin
                aluOp         = aluClr;
                wrEnReg[wrAc] = 1'b1;
                zWrEn         = 1'b1;
            end

            stepFetchWait, stepFetch1, stepLdiacWait1, stepLdiac1,
            stepStirWait1, stepStir1: begin
                wrEnReg[wrIr] = 1'b1;  // IR <- memory at PC
            end

            stepFetch2: begin
                incReg[incPc] = 1'b1;
                busSel        = busDMem;
            end

            stepLdiac2, stepStir2: begin
                incReg[incPc] = 1'b1;
                wrEnReg[wrAr] = 1'b1;  // address word from IR
                busSel        = busIR;
            end

            stepLdiacWait2, stepLdiac3, stepLdacWait, stepLdac2: begin
                aluOp         = aluPass;
                wrEnReg[wrAc] = 1'b1;
                busSel        = busDMem;
                zWrEn         = 1'b1;
            end

            stepLdac1, stepStr1: begin
                wrEnReg[wrAr] = 1'b1;  // AC holds the address
                busSel        = busAC;
            end

            stepStrWait, stepStr2, stepStirWait2, stepStir3: begin
                dMemWrEn = 1'b1;
            end

            stepJumpWait, stepJump1, stepJmpnzYWait, stepJmpnzY1,
            stepJmpzYWait, stepJmpzY1: begin
                wrEnReg[wrIr] = 1'b1;  // target address into IR
                busSel        = busDMem;
            end

            stepJump2, stepJmpnzY2, stepJmpzY2: begin
                wrEnReg[wrPc] = 1'b1;
                busSel        = busIR;
            end

            stepJmpnzN, stepJmpzN: begin
                incReg[incPc] = 1'b1;  // skip the address word
            end

            stepMul: begin
                aluOp         = aluMul;
                incReg[incRc] = 1'b1;
                incReg[incRp] = 1'b1;
                incReg[incRq] = 1'b1;
                wrEnReg[wrAc] = 1'b1;
                busSel        = busR1;
                zWrEn         = 1'b1;
            end

            stepAdd, stepSub, stepIncac, stepMvAcRp, stepMvAcRq, stepMvAcRl: begin
                wrEnReg[wrAc] = 1'b1;
                zWrEn         = 1'b1;
                case (step)
                    stepAdd: begin
                        aluOp  = aluAdd;
                        busSel = busR;
                    end
                    stepSub: begin
                        aluOp  = aluSub;
                        busSel = busRC;
                    end
                    stepIncac:  aluOp = aluInc;
                    stepMvAcRp: {aluOp, busSel} = {aluPass, busRP};
                    stepMvAcRq: {aluOp, busSel} = {aluPass, busRQ};
                    default:    {aluOp, busSel} = {aluPass, busRL};
                endcase
            end

            // moves from AC set one write enable each
            stepMvRlAc: {wrEnReg[wrRl], busSel} = {1'b1, busAC};
            stepMvRpAc: {wrEnReg[wrRp], busSel} = {1'b1, busAC};
            stepMvRqAc: {wrEnReg[wrRq], busSel} = {1'b1, busAC};
            stepMvRcAc: {wrEnReg[wrRc], busSel} = {1'b1, busAC};
            stepMvRAc:  {wrEnReg[wrR], busSel}  = {1'b1, busAC};
            stepMvR1Ac: {wrEnReg[wrR1], busSel} = {1'b1, busAC};

            default: begin
            end
        endcase
    end

    assign done  = (step == stepEndop);
    assign ready = (step == stepIdle);

endmodule

//--- source/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer
    import controlPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,  // active low
    input  logic      zout,
    input  instrKindT kind,
    output stepT      step
);

    stepT nextStep;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            step <= stepIdle;
        end else begin
            step <= nextStep;
        end
    end

    // first step of each instruction as chosen in stepFetch2
    function automatic stepT dispatch(input instrKindT k, input logic z);
        stepT s;
        case (k)
            kindNop:    s = stepNop;
            kindEndop:  s = stepEndop;
            kindClac:   s = stepClac;
            kindLdiac:  s = stepLdiacWait1;
            kindLdac:   s = stepLdac1;
            kindStr:    s = stepStr1;
            kindStir:   s = stepStirWait1;
            kindJump:   s = stepJumpWait;
            kindJmpnz:  s = z ? stepJmpnzN : stepJmpnzYWait;  // taken when zero flag clear
            kindJmpz:   s = z ? stepJmpzYWait : stepJmpzN;
            kindMul:    s = stepMul;
            kindAdd:    s = stepAdd;
            kindSub:    s = stepSub;
            kindIncac:  s = stepIncac;
            kindMvRlAc: s = stepMvRlAc;
            kindMvRpAc: s = stepMvRpAc;
            kindMvRqAc: s = stepMvRqAc;
            kindMvRcAc: s = stepMvRcAc;
            kindMvRAc:  s = stepMvRAc;
            kindMvR1Ac: s = stepMvR1Ac;
            kindMvAcRp: s = stepMvAcRp;
            kindMvAcRq: s = stepMvAcRq;
            kindMvAcRl: s = stepMvAcRl;
            default:    s = stepIdle;
        endcase
        return s;
    endfunction

    always_comb begin
        case (step)
            stepIdle:       nextStep = start ? stepIdle : stepFetch1;
            stepEndop:      nextStep = stepEndop;  // halt until reset
            stepNop:        nextStep = stepFetch1;
            stepFetchWait:  nextStep = stepFetch1;
            stepFetch1:     nextStep = stepFetch2;
            stepFetch2:     nextStep = dispatch(kind, zout);

            stepLdiacWait1: nextStep = stepLdiac1;
            stepLdiac1:     nextStep = stepLdiac2;
            stepLdiac2:     nextStep = stepLdiacWait2;
            stepLdiacWait2: nextStep = stepLdiac3;

            stepLdac1:      nextStep = stepLdacWait;
            stepLdacWait:   nextStep = stepLdac2;

            stepStirWait1:  nextStep = stepStir1;
            stepStir1:      nextStep = stepStir2;
            stepStir2:      nextStep = stepStirWait2;
            stepStirWait2:  nextStep = stepStir3;

            stepStr1:       nextStep = stepStrWait;
            stepStrWait:    nextStep = stepStr2;
            stepStr2:       nextStep = stepFetch1;  // no extra wait after a store

            stepJumpWait:   nextStep = stepJump1;
            stepJump1:      nextStep = stepJump2;
            stepJmpnzYWait: nextStep = stepJmpnzY1;
            stepJmpnzY1:    nextStep = stepJmpnzY2;
            stepJmpzYWait:  nextStep = stepJmpzY1;
            stepJmpzY1:     nextStep = stepJmpzY2;

            // last steps (ldiac3, ldac2, stir3, jumps, alu, moves) end through the fetch wait
            default:        nextStep = stepFetchWait;
        endcase
    end

endmodule

//--- source/opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder
    import controlPkg::*;
(
    input  instrT     ins,
    output instrKindT kind
);

    always_comb begin
        case (ins)
            opNop:    kind = kindNop;
            opEndop:  kind = kindEndop;
            opClac:   kind = kindClac;
            opLdiac:  kind = kindLdiac;
            opLdac:   kind = kindLdac;
            opStr:    kind = kindStr;
            opStir:   kind = kindStir;
            opJump:   kind = kindJump;
            opJmpnz:  kind = kindJmpnz;
            opJmpz:   kind = kindJmpz;
            opMul:    kind = kindMul;
            opAdd:    kind = kindAdd;
            opSub:    kind = kindSub;
            opIncac:  kind = kindIncac;

            // register moves share the low nibble 4'hf
            opMvRlAc: kind = kindMvRlAc;
            opMvRpAc: kind = kindMvRpAc;
            opMvRqAc: kind = kindMvRqAc;
            opMvRcAc: kind = kindMvRcAc;
            opMvRAc:  kind = kindMvRAc;
            opMvR1Ac: kind = kindMvR1Ac;
            opMvAcRp: kind = kindMvAcRp;
            opMvAcRq: kind = kindMvAcRq;
            opMvAcRl: kind = kindMvAcRl;
            default:  kind = kindInvalid;  // unknown byte sends the sequencer back to idle
        endcase
    end

endmodule

//--- source/controlPkg.sv
package controlPkg;

    localparam int instrWidth = 8;

    typedef logic [instrWidth-1:0] instrT;
    typedef logic [2:0] aluOpT;
    typedef logic [3:0] incVecT;   // {PC, RC, RP, RQ}
    typedef logic [9:0] wrEnVecT;  // {AR, R, PC, IR, RL, RC, RP, RQ, R1, AC}
    typedef logic [3:0] busSelT;

    localparam aluOpT aluClr  = 3'd0;
    localparam aluOpT aluPass = 3'd1;
    localparam aluOpT aluAdd  = 3'd2;
    localparam aluOpT aluSub  = 3'd3;
    localparam aluOpT aluMul  = 3'd4;
    localparam aluOpT aluInc  = 3'd5;
    localparam aluOpT aluNone = 3'd6;  // no ALU operation this step

    localparam busSelT busDMem = 4'd0;
    localparam busSelT busR    = 4'd1;
    localparam busSelT busIR   = 4'd2;
    localparam busSelT busRL   = 4'd3;
    localparam busSelT busRC   = 4'd4;
    localparam busSelT busRP   = 4'd5;
    localparam busSelT busRQ   = 4'd6;
    localparam busSelT busR1   = 4'd7;
    localparam busSelT busAC   = 4'd8;
    localparam busSelT busNone = 4'd9;

    localparam instrT opNop   = 8'd0;
    localparam instrT opEndop = 8'd1;
    localparam instrT opClac  = 8'd2;
    localparam instrT opLdiac = 8'd3;
    localparam instrT opLdac  = 8'd4;
    localparam instrT opStr   = 8'd5;
    localparam instrT opStir  = 8'd6;
    localparam instrT opJump  = 8'd7;
    localparam instrT opJmpnz = 8'd8;
    localparam instrT opJmpz  = 8'd9;
    localparam instrT opMul   = 8'd10;
    localparam instrT opAdd   = 8'd11;
    localparam instrT opSub   = 8'd12;
    localparam instrT opIncac = 8'd13;

    // move opcodes carry the selector in the high nibble and 4'hf in the low nibble
    localparam instrT opMvRlAc = {4'd1, 4'd15};
    localparam instrT opMvRpAc = {4'd2, 4'd15};
    localparam instrT opMvRqAc = {4'd3, 4'd15};
    localparam instrT opMvRcAc = {4'd4, 4'd15};
    localparam instrT opMvRAc  = {4'd5, 4'd15};
    localparam instrT opMvR1Ac = {4'd6, 4'd15};
    localparam instrT opMvAcRp = {4'd7, 4'd15};
    localparam instrT opMvAcRq = {4'd8, 4'd15};
    localparam instrT opMvAcRl = {4'd9, 4'd15};

    localparam int wrAr = 9;
    localparam int wrR  = 8;
    localparam int wrPc = 7;
    localparam int wrIr = 6;
    localparam int wrRl = 5;
    localparam int wrRc = 4;
    localparam int wrRp = 3;
    localparam int wrRq = 2;
    localparam int wrR1 = 1;
    localparam int wrAc = 0;

    localparam int incPc = 3;
    localparam int incRc = 2;
    localparam int incRp = 1;
    localparam int incRq = 0;

    typedef enum logic [4:0] {
        kindNop, kindEndop, kindClac, kindLdiac, kindLdac, kindStr, kindStir,
        kindJump, kindJmpnz, kindJmpz, kindMul, kindAdd, kindSub, kindIncac,
        kindMvRlAc, kindMvRpAc, kindMvRqAc, kindMvRcAc, kindMvRAc, kindMvR1Ac,
        kindMvAcRp, kindMvAcRq, kindMvAcRl, kindInvalid
    } instrKindT;

    typedef enum logic [5:0] {
        stepIdle, stepNop, stepEndop, stepClac,
        stepFetchWait, stepFetch1, stepFetch2,
        stepLdiacWait1, stepLdiac1, stepLdiac2, stepLdiacWait2, stepLdiac3,
        stepLdac1, stepLdacWait, stepLdac2,
        stepStirWait1, stepStir1, stepStir2, stepStirWait2, stepStir3,
        stepStr1, stepStrWait, stepStr2,
        stepJumpWait, stepJump1, stepJump2,
        stepJmpnzYWait, stepJmpnzY1, stepJmpnzY2, stepJmpnzN,
        stepJmpzYWait, stepJmpzY1, stepJmpzY2, stepJmpzN,
        stepMul, stepAdd, stepSub, stepIncac,
        stepMvRlAc, stepMvRpAc, stepMvRqAc, stepMvRcAc, stepMvRAc, stepMvR1Ac,
        stepMvAcRp, stepMvAcRq, stepMvAcRl
    } stepT;

endpackage
